//--- hdl/region_config.svh
`ifndef REGION_CONFIG_SVH
`define REGION_CONFIG_SVH

// Data word width in bits
`define REGION_WIDTH 8

// Address bits, shared by memory and queue
`define REGION_LOG2_DEPTH 5

// Peer channels sharing the region
`define REGION_NUM_CHANNELS 3

// Almost full once count reaches depth minus this margin
`define REGION_AF_MARGIN 4

`endif

//--- hdl/region_mem_pkg.sv
`default_nettype none

`include "region_config.svh"

package region_mem_pkg;

    typedef logic [`REGION_WIDTH-1:0] data_t;

    typedef logic [`REGION_LOG2_DEPTH-1:0] addr_t;

    // One bit wider than addr_t so a full queue can be counted
    typedef logic [`REGION_LOG2_DEPTH:0] count_t;

endpackage

`default_nettype wire

//--- hdl/region_chan_pkg.sv
`default_nettype none

`include "region_config.svh"

package region_chan_pkg;

    // Write view, one enable per target
    typedef struct packed {
        logic fifo_en;
        logic mem_en;
    } target_mask_t;

    // Same two bits, decoded as a code by reads and as a mask by writes
    typedef union packed {
        logic [1:0]   code;
        target_mask_t mask;
    } target_sel_u;

    localparam logic [1:0] TGT_MEM  = 2'b01;
    localparam logic [1:0] TGT_FIFO = 2'b10;

    typedef logic [$clog2(`REGION_NUM_CHANNELS > 1 ? `REGION_NUM_CHANNELS : 2)-1:0]
        chan_idx_t;

endpackage

`default_nettype wire

//--- hdl/region_bram.sv
`timescale 1ns/10ps
`default_nettype none

`include "region_config.svh"

module region_bram (
    input  wire                   clk,

    input  wire                   mem_re,
    input  wire region_mem_pkg::addr_t mem_raddr,
    output region_mem_pkg::data_t mem_rdata,

    input  wire                   mem_we,
    input  wire region_mem_pkg::addr_t mem_waddr,
    input  wire region_mem_pkg::data_t mem_wdata
);

    localparam int DEPTH = 1 << `REGION_LOG2_DEPTH;

    region_mem_pkg::data_t mem [DEPTH];

    // ********************************************************
    // Write port
    // ********************************************************
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // ********************************************************
    // Read port
    // ********************************************************
    // Same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rdata <= mem[mem_raddr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/region_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "region_config.svh"

module region_fifo (
    input  wire                    clk,
    input  wire                    arst_n,

    input  wire                    fifo_we,
    input  wire region_mem_pkg::data_t fifo_wdata,

    input  wire                    fifo_re,
    output logic                   fifo_rvalid,
    output region_mem_pkg::data_t  fifo_rdata,

    output logic                   fifo_empty,
    output logic                   fifo_almost_full,
    output region_mem_pkg::count_t fifo_count
);

    localparam int DEPTH = 1 << `REGION_LOG2_DEPTH;

    region_mem_pkg::data_t buffer [DEPTH];
    region_mem_pkg::addr_t wr_ptr;
    region_mem_pkg::addr_t rd_ptr;

    logic full;
    logic do_write;
    logic do_read;

    // ********************************************************
    // Status
    // ********************************************************
    assign full             = (fifo_count == region_mem_pkg::count_t'(DEPTH));
    assign fifo_empty       = (fifo_count == '0);
    assign fifo_almost_full =
        (fifo_count >= region_mem_pkg::count_t'(DEPTH - `REGION_AF_MARGIN));

    // Full drops the write, empty drops the read
    assign do_write = fifo_we && !full;
    assign do_read  = fifo_re && !fifo_empty;

    // ********************************************************
    // Pointers and count
    // ********************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fifo_count  <= '0;
            fifo_rvalid <= 1'b0;
        end else begin
            fifo_rvalid <= do_read;
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // ********************************************************
    // Storage
    // ********************************************************
    always_ff @(posedge clk) begin
        if (do_write) begin
            buffer[wr_ptr] <= fifo_wdata;
        end
        if (do_read) begin
            fifo_rdata <= buffer[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/region_read_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "region_config.svh"

module region_read_arbiter (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         re     [`REGION_NUM_CHANNELS],
    input  wire region_chan_pkg::target_sel_u rsel [`REGION_NUM_CHANNELS],
    input  wire region_mem_pkg::addr_t  raddr  [`REGION_NUM_CHANNELS],
    output logic                        rvalid [`REGION_NUM_CHANNELS],
    output region_mem_pkg::data_t       rdata  [`REGION_NUM_CHANNELS],

    output logic                        mem_re,
    output region_mem_pkg::addr_t       mem_raddr,
    output logic                        fifo_re,
    input  wire                         fifo_rvalid,
    input  wire region_mem_pkg::data_t  fifo_rdata,
    input  wire region_mem_pkg::data_t  mem_rdata
);

    localparam int NCH = `REGION_NUM_CHANNELS;

    region_chan_pkg::chan_idx_t mem_idx;
    region_chan_pkg::chan_idx_t fifo_idx;

    logic grant_q    [NCH];
    logic fifo_tgt_q [NCH];

    // ********************************************************
    // Fixed priority, lowest channel wins per target
    // ********************************************************
    always_comb begin
        mem_re    = 1'b0;
        mem_raddr = '0;
        mem_idx   = '0;
        fifo_re   = 1'b0;
        fifo_idx  = '0;
        for (int i = 0; i < NCH; i++) begin
            if (re[i] && !mem_re && rsel[i].code == region_chan_pkg::TGT_MEM) begin
                mem_re    = 1'b1;
                mem_raddr = raddr[i];
                mem_idx   = region_chan_pkg::chan_idx_t'(i);
            end
            if (re[i] && !fifo_re && rsel[i].code == region_chan_pkg::TGT_FIFO) begin
                fifo_re  = 1'b1;
                fifo_idx = region_chan_pkg::chan_idx_t'(i);
            end
        end
    end

    // ********************************************************
    // Return routing
    // ********************************************************
    for (genvar i = 0; i < NCH; i++) begin : gen_chan
        logic mem_hit;
        logic fifo_hit;

        assign mem_hit  = mem_re && (mem_idx == region_chan_pkg::chan_idx_t'(i));
        assign fifo_hit = fifo_re && (fifo_idx == region_chan_pkg::chan_idx_t'(i));

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                grant_q[i]    <= 1'b0;
                fifo_tgt_q[i] <= 1'b0;
            end else begin
                grant_q[i]    <= mem_hit || fifo_hit;
                fifo_tgt_q[i] <= fifo_hit;
            end
        end

        // Queue grant gets nothing back if the queue was empty
        assign rvalid[i] = grant_q[i] && (!fifo_tgt_q[i] || fifo_rvalid);
        assign rdata[i]  = fifo_tgt_q[i] ? fifo_rdata : mem_rdata;
    end

endmodule

`default_nettype wire

//--- hdl/region_write_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "region_config.svh"

module region_write_arbiter (
    input  wire                         clk,
    input  wire                         arst_n,

    input  wire                         we    [`REGION_NUM_CHANNELS],
    input  wire region_chan_pkg::target_sel_u wsel [`REGION_NUM_CHANNELS],
    input  wire region_mem_pkg::addr_t  waddr [`REGION_NUM_CHANNELS],
    input  wire region_mem_pkg::data_t  wdata [`REGION_NUM_CHANNELS],

    output logic                        mem_we,
    output region_mem_pkg::addr_t       mem_waddr,
    output region_mem_pkg::data_t       mem_wdata,
    output logic                        fifo_we,
    output region_mem_pkg::data_t       fifo_wdata
);

    localparam int NCH = `REGION_NUM_CHANNELS;

    logic                  mem_hit;
    logic                  fifo_hit;
    region_mem_pkg::addr_t mem_sel_addr;
    region_mem_pkg::data_t mem_sel_data;
    region_mem_pkg::data_t fifo_sel_data;

    // ********************************************************
    // Mask decode, independent grant per target
    // ********************************************************
    always_comb begin
        mem_hit       = 1'b0;
        fifo_hit      = 1'b0;
        mem_sel_addr  = '0;
        mem_sel_data  = '0;
        fifo_sel_data = '0;
        for (int i = 0; i < NCH; i++) begin
            if (we[i] && wsel[i].mask.mem_en && !mem_hit) begin
                mem_hit      = 1'b1;
                mem_sel_addr = waddr[i];
                mem_sel_data = wdata[i];
            end
            if (we[i] && wsel[i].mask.fifo_en && !fifo_hit) begin
                fifo_hit      = 1'b1;
                fifo_sel_data = wdata[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_we  <= 1'b0;
            fifo_we <= 1'b0;
        end else begin
            mem_we  <= mem_hit;
            fifo_we <= fifo_hit;
        end
    end

    // Winning payload, held until the next grant
    always_ff @(posedge clk) begin
        if (mem_hit) begin
            mem_waddr <= mem_sel_addr;
            mem_wdata <= mem_sel_data;
        end
        if (fifo_hit) begin
            fifo_wdata <= fifo_sel_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/region.sv
`timescale 1ns/10ps
`default_nettype none

`include "region_config.svh"

module region (
    input  wire                          clk,
    input  wire                          arst_n,

    input  wire                          re     [`REGION_NUM_CHANNELS],
    input  wire region_chan_pkg::target_sel_u rsel [`REGION_NUM_CHANNELS],
    input  wire region_mem_pkg::addr_t   raddr  [`REGION_NUM_CHANNELS],
    output logic                         rvalid [`REGION_NUM_CHANNELS],
    output region_mem_pkg::data_t        rdata  [`REGION_NUM_CHANNELS],

    input  wire                          we     [`REGION_NUM_CHANNELS],
    input  wire region_chan_pkg::target_sel_u wsel [`REGION_NUM_CHANNELS],
    input  wire region_mem_pkg::addr_t   waddr  [`REGION_NUM_CHANNELS],
    input  wire region_mem_pkg::data_t   wdata  [`REGION_NUM_CHANNELS],

    // Queue status, common to all channels
    output logic                         fifo_empty,
    output logic                         fifo_almost_full,
    output region_mem_pkg::count_t       fifo_count
);

    logic                  mem_re;
    region_mem_pkg::addr_t mem_raddr;
    region_mem_pkg::data_t mem_rdata;
    logic                  mem_we;
    region_mem_pkg::addr_t mem_waddr;
    region_mem_pkg::data_t mem_wdata;

    logic                  fifo_re;
    logic                  fifo_rvalid;
    region_mem_pkg::data_t fifo_rdata;
    logic                  fifo_we;
    region_mem_pkg::data_t fifo_wdata;

    // ********************************************************
    // Arbiters
    // ********************************************************
    region_read_arbiter read_arb_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .re          (re),
        .rsel        (rsel),
        .raddr       (raddr),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .mem_re      (mem_re),
        .mem_raddr   (mem_raddr),
        .fifo_re     (fifo_re),
        .fifo_rvalid (fifo_rvalid),
        .fifo_rdata  (fifo_rdata),
        .mem_rdata   (mem_rdata)
    );

    region_write_arbiter write_arb_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .we         (we),
        .wsel       (wsel),
        .waddr      (waddr),
        .wdata      (wdata),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .fifo_we    (fifo_we),
        .fifo_wdata (fifo_wdata)
    );

    // ********************************************************
    // Storage
    // ********************************************************
    region_bram bram_inst (
        .clk       (clk),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

    region_fifo fifo_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .fifo_we          (fifo_we),
        .fifo_wdata       (fifo_wdata),
        .fifo_re          (fifo_re),
        .fifo_rvalid      (fifo_rvalid),
        .fifo_rdata       (fifo_rdata),
        .fifo_empty       (fifo_empty),
        .fifo_almost_full (fifo_almost_full),
        .fifo_count       (fifo_count)
    );

endmodule

`default_nettype wire

//--- dv/region_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "region_config.svh"

module region_tb;

    localparam int NCH      = `REGION_NUM_CHANNELS;
    localparam int DEPTH    = 1 << `REGION_LOG2_DEPTH;
    localparam int AF_LEVEL = DEPTH - `REGION_AF_MARGIN;

    // Limit sits well above the rough length of all tests
    localparam int TEST_CYCLES    = 450;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES + 200;

    logic                         clk;
    logic                         arst_n;
    logic                         re     [NCH];
    region_chan_pkg::target_sel_u rsel   [NCH];
    region_mem_pkg::addr_t        raddr  [NCH];
    logic                         rvalid [NCH];
    region_mem_pkg::data_t        rdata  [NCH];
    logic                         we     [NCH];
    region_chan_pkg::target_sel_u wsel   [NCH];
    region_mem_pkg::addr_t        waddr  [NCH];
    region_mem_pkg::data_t        wdata  [NCH];
    logic                         fifo_empty;
    logic                         fifo_almost_full;
    region_mem_pkg::count_t       fifo_count;

    // Reference models
    region_mem_pkg::data_t mem_model [DEPTH];
    region_mem_pkg::data_t fifo_model [$];

    int pass_count;
    int fail_count;
    int fails_before;
    int cycles;

    region region_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .re               (re),
        .rsel             (rsel),
        .raddr            (raddr),
        .rvalid           (rvalid),
        .rdata            (rdata),
        .we               (we),
        .wsel             (wsel),
        .waddr            (waddr),
        .wdata            (wdata),
        .fifo_empty       (fifo_empty),
        .fifo_almost_full (fifo_almost_full),
        .fifo_count       (fifo_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ************************************************************
    // Checks
    // ************************************************************
    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        assert (got === exp) begin
            pass_count++;
        end else begin
            $display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            fail_count++;
        end
    endtask

    task automatic expect_rvalid(input logic [NCH-1:0] exp, input string what);
        for (int i = 0; i < NCH; i++) begin
            expect_equal(32'(rvalid[i]), 32'(exp[i]), $sformatf("%s rvalid[%0d]", what, i));
        end
    endtask

    task automatic expect_status(input int cnt, input string what);
        expect_equal(32'(fifo_count), 32'(cnt), {what, " count"});
        expect_equal(32'(fifo_empty), 32'(cnt == 0), {what, " empty"});
        expect_equal(32'(fifo_almost_full), 32'(cnt >= AF_LEVEL), {what, " almost full"});
    endtask

    task automatic report_test(input string name);
        if (fail_count == fails_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    // ************************************************************
    // Stimulus
    // ************************************************************
    // Strobes drop at each rising edge unless driven again
    task automatic next_cycle();
        @(posedge clk);
        for (int i = 0; i < NCH; i++) begin
            re[i] <= 1'b0;
            we[i] <= 1'b0;
        end
    endtask

    task automatic drive_read(input int ch, input logic [1:0] code,
                              input region_mem_pkg::addr_t addr);
        re[ch]        <= 1'b1;
        rsel[ch].code <= code;
        raddr[ch]     <= addr;
    endtask

    task automatic drive_write(input int ch, input logic [1:0] mask,
                               input region_mem_pkg::addr_t addr,
                               input region_mem_pkg::data_t data);
        we[ch]                <= 1'b1;
        wsel[ch].mask.fifo_en <= mask[1];
        wsel[ch].mask.mem_en  <= mask[0];
        waddr[ch]             <= addr;
        wdata[ch]             <= data;
    endtask

    // Count trails each write by two cycles from an empty queue
    task automatic fill_queue(input int n, input string what);
        region_mem_pkg::data_t d;
        int                    exp_cnt;
        for (int j = 0; j <= n + 1; j++) begin
            next_cycle();
            if (j < n) begin
                d = region_mem_pkg::data_t'($urandom);
                drive_write(j % NCH, 2'b10, '0, d);
                if (fifo_model.size() < DEPTH) begin
                    fifo_model.push_back(d);
                end
            end
            @(negedge clk);
            exp_cnt = (j < 2) ? 0 : j - 1;
            if (exp_cnt > DEPTH) begin
                exp_cnt = DEPTH;
            end
            expect_status(exp_cnt, what);
        end
    endtask

    // One pipelined read per cycle over rotating channels
    task automatic drain_queue(input int n, input string what);
        logic [NCH-1:0] exp_v;
        for (int j = 0; j <= n; j++) begin
            next_cycle();
            if (j < n) begin
                drive_read(j % NCH, region_chan_pkg::TGT_FIFO, '0);
            end
            @(negedge clk);
            exp_v = '0;
            if (j > 0) begin
                exp_v[(j - 1) % NCH] = 1'b1;
                expect_equal(32'(rdata[(j - 1) % NCH]), 32'(fifo_model.pop_front()),
                             {what, " rdata"});
            end
            expect_rvalid(exp_v, what);
            expect_status(n - j, what);
        end
    endtask

    // ************************************************************
    // Tests
    // ************************************************************
    initial begin
        region_mem_pkg::addr_t addrs [8];
        region_mem_pkg::addr_t a;
        region_mem_pkg::data_t d;
        region_mem_pkg::data_t dq;
        logic [NCH-1:0]        exp_v;

        void'($urandom(32'h87f47cb7));
        pass_count   = 0;
        fail_count   = 0;
        fails_before = 0;
        arst_n <= 1'b0;
        for (int i = 0; i < NCH; i++) begin
            re[i]    <= 1'b0;
            rsel[i]  <= '0;
            raddr[i] <= '0;
            we[i]    <= 1'b0;
            wsel[i]  <= '0;
            waddr[i] <= '0;
            wdata[i] <= '0;
        end

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        expect_rvalid('0, "reset");
        expect_status(0, "reset");
        report_test("reset");

        for (int k = 0; k < 8; k++) begin
            next_cycle();
            addrs[k] = region_mem_pkg::addr_t'($urandom);
            d = region_mem_pkg::data_t'($urandom);
            drive_write(2, 2'b01, addrs[k], d);
            mem_model[addrs[k]] = d;
        end
        // Last write commits one cycle after its grant
        next_cycle();
        for (int k = 0; k <= 8; k++) begin
            next_cycle();
            if (k < 8) begin
                drive_read(k % 2, region_chan_pkg::TGT_MEM, addrs[k]);
            end
            @(negedge clk);
            exp_v = '0;
            if (k > 0) begin
                exp_v[(k - 1) % 2] = 1'b1;
                expect_equal(32'(rdata[(k - 1) % 2]), 32'(mem_model[addrs[k - 1]]),
                             "memory rdata");
            end
            expect_rvalid(exp_v, "memory");
        end
        report_test("memory");

        fill_queue(6, "queue fill");
        drain_queue(6, "queue drain");
        next_cycle();
        drive_read(1, region_chan_pkg::TGT_FIFO, '0);
        next_cycle();
        @(negedge clk);
        expect_rvalid('0, "empty queue read");
        expect_status(0, "empty queue read");
        report_test("queue");

        a  = region_mem_pkg::addr_t'($urandom);
        d  = region_mem_pkg::data_t'($urandom);
        dq = region_mem_pkg::data_t'($urandom);
        next_cycle();
        drive_write(0, 2'b10, '0, dq);
        drive_write(1, 2'b01, a, d);
        drive_write(2, 2'b01, a, ~d);
        mem_model[a] = d;
        fifo_model.push_back(dq);
        next_cycle();
        next_cycle();
        next_cycle();
        drive_read(0, region_chan_pkg::TGT_MEM, a);
        drive_read(2, region_chan_pkg::TGT_MEM, a);
        next_cycle();
        drive_read(0, region_chan_pkg::TGT_MEM, a);
        drive_read(1, region_chan_pkg::TGT_MEM, a);
        drive_read(2, region_chan_pkg::TGT_FIFO, '0);
        @(negedge clk);
        expect_rvalid(NCH'(3'b001), "memory priority");
        expect_equal(32'(rdata[0]), 32'(mem_model[a]), "memory priority rdata");
        next_cycle();
        @(negedge clk);
        expect_rvalid(NCH'(3'b101), "mixed priority");
        expect_equal(32'(rdata[0]), 32'(mem_model[a]), "mixed priority memory rdata");
        expect_equal(32'(rdata[2]), 32'(fifo_model.pop_front()), "mixed priority queue rdata");
        expect_status(0, "priority");
        report_test("priority");

        a = region_mem_pkg::addr_t'($urandom);
        d = region_mem_pkg::data_t'($urandom);
        next_cycle();
        drive_write(1, 2'b11, a, d);
        mem_model[a] = d;
        fifo_model.push_back(d);
        next_cycle();
        next_cycle();
        drive_read(0, region_chan_pkg::TGT_MEM, a);
        drive_read(1, region_chan_pkg::TGT_FIFO, '0);
        @(negedge clk);
        expect_status(1, "broadcast");
        next_cycle();
        @(negedge clk);
        expect_rvalid(NCH'(3'b011), "broadcast");
        expect_equal(32'(rdata[0]), 32'(mem_model[a]), "broadcast memory rdata");
        expect_equal(32'(rdata[1]), 32'(fifo_model.pop_front()), "broadcast queue rdata");
        expect_status(0, "broadcast");
        report_test("broadcast");

        // Last write goes one past the depth
        fill_queue(DEPTH + 1, "full fill");
        drain_queue(DEPTH, "full drain");
        report_test("full queue");

        $display("Summary: %0d checks ok, %0d checks wrong", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/region_mem_pkg.sv
hdl/region_chan_pkg.sv
hdl/region_bram.sv
hdl/region_fifo.sv
hdl/region_read_arbiter.sv
hdl/region_write_arbiter.sv
hdl/region.sv
dv/region_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module region_tb -o region_tb_sim

output=$(./obj_dir/region_tb_sim)
echo "$output"

if grep -qx "All checks passed" <<< "$output"; then
    exit 0
fi
exit 1
